// ==== sim.f ====
verilog/lcd_ahb_pkg.sv
verilog/ahb_slave_ctrl.sv
verilog/lcd_timing_regs.sv
verilog/lcd_cursor_regs.sv
verilog/lcd_ahb_regs.sv
verification/lcd_ahb_checker.sv
verification/tb_lcd_ahb_regs.sv

// ==== Makefile ====
# Verilator flow for the LCD AHB-Lite register file

VERILATOR ?= verilator
TOP       ?= tb_lcd_ahb_regs
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_lcd_ahb_regs.sv ====
// testbench top for the LCD AHB-Lite register file
// clock, reset, LFSR driven random AHB transfers, DUT, checker and timeout

`timescale 1ns/100ps

module tb_lcd_ahb_regs;

   localparam lcd_ahb_pkg::ahb_addr_t LCD_BASE = 32'hFFE1_0000;
   localparam int NUM_TRANSFERS  = 400;
   localparam int TIMEOUT_CYCLES = 3 * NUM_TRANSFERS + 50;

   logic                   HCLK;
   logic                   HRESET;
   logic                   HSEL;
   logic                   HWRITE;
   lcd_ahb_pkg::ahb_addr_t HADDR;
   lcd_ahb_pkg::htrans_t   HTRANS;
   lcd_ahb_pkg::ahb_data_t HWDATA;
   lcd_ahb_pkg::ahb_data_t HRDATA;
   logic                   HREADY;
   lcd_ahb_pkg::ahb_data_t lcd_timh, lcd_timv, lcd_pol, lcd_le;
   lcd_ahb_pkg::ahb_data_t lcd_upbase, lcd_lpbase, lcd_ctrl;
   lcd_ahb_pkg::ahb_data_t crsr_ctrl, crsr_cfg, crsr_pal0;
   lcd_ahb_pkg::ahb_data_t crsr_pal1, crsr_xy, crsr_clip;
   int                     error_count;
   int                     cycle_count = 0;
   logic [15:0]            lfsr_q;
   lcd_ahb_pkg::ahb_data_t pending_data;

   lcd_ahb_regs #(.LCD_BASE (LCD_BASE)) i_dut (.*);

   lcd_ahb_checker #(.LCD_BASE (LCD_BASE)) i_checker (.*);

   always #5 HCLK = ~HCLK;

   // ================================================
   // random source
   // ================================================

   // taps for x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // one step per bit, newest bit ends up in bit 0
   task automatic draw_bits(input int nbits, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         val    = {val[30:0], lfsr_q[0]};
      end
   endtask

   // mostly NONSEQ, the rest split over IDLE, SEQ and BUSY
   function automatic lcd_ahb_pkg::htrans_t pick_htrans(input logic [2:0] code);
      case (code)
         3'd5:    return lcd_ahb_pkg::HTRANS_IDLE;
         3'd6:    return lcd_ahb_pkg::HTRANS_SEQ;
         3'd7:    return lcd_ahb_pkg::HTRANS_BUSY;
         default: return lcd_ahb_pkg::HTRANS_NONSEQ;
      endcase
   endfunction

   // mapped register, unmapped index, unused block or off-page
   task automatic pick_address(output lcd_ahb_pkg::ahb_addr_t addr);
      logic [31:0] kind;
      logic [31:0] blk;
      logic [31:0] idx;
      logic [31:0] low;
      logic [31:0] page;
      logic [31:0] word_idx;
      draw_bits(3, kind);
      draw_bits(1, blk);
      draw_bits(4, idx);
      draw_bits(6, low);
      addr       = {LCD_BASE[31:12], 12'h000};
      addr[9:6]  = low[5:2];
      addr[1:0]  = low[1:0];
      addr[11:10] = blk[0] ? lcd_ahb_pkg::CRSR_BLOCK_SEL : lcd_ahb_pkg::LCD_BLOCK_SEL;
      case (kind[2:0])
         3'd5: word_idx = blk[0] ? 6 + idx % 10 : 7 + idx % 9;
         3'd6: begin
            word_idx    = idx;
            addr[11:10] = blk[0] ? 2'd2 : 2'd1;
         end
         3'd7: begin
            draw_bits(20, page);
            word_idx     = idx;
            addr[31:12] = LCD_BASE[31:12] ^ (page[19:0] | 20'h00001);
         end
         default: word_idx = blk[0] ? idx % 6 : idx % 7;
      endcase
      addr[5:2] = word_idx[3:0];
   endtask

   // ================================================
   // stimulus
   // ================================================

   initial begin
      logic [31:0]            sel_bits;
      logic [31:0]            trans_bits;
      logic [31:0]            write_bit;
      logic [31:0]            data;
      lcd_ahb_pkg::ahb_addr_t addr;
      HCLK         = 1'b0;
      HRESET       = 1'b0;
      HSEL         = 1'b0;
      HWRITE       = 1'b0;
      HADDR        = '0;
      HTRANS       = lcd_ahb_pkg::HTRANS_IDLE;
      HWDATA       = '0;
      lfsr_q       = 16'd25;
      pending_data = '0;
      repeat (2) @(posedge HCLK);
      HRESET <= 1'b1;
      for (int n = 0; n < NUM_TRANSFERS; n++) begin
         @(posedge HCLK);
         draw_bits(3, sel_bits);
         draw_bits(3, trans_bits);
         draw_bits(1, write_bit);
         pick_address(addr);
         draw_bits(32, data);
         HSEL   <= (sel_bits[2:0] != 3'd0);
         HTRANS <= pick_htrans(trans_bits[2:0]);
         HWRITE <= write_bit[0];
         HADDR  <= addr;
         // write data trails its address by one cycle
         HWDATA <= pending_data;
         pending_data = data;
      end
      @(posedge HCLK);
      HSEL   <= 1'b0;
      HTRANS <= lcd_ahb_pkg::HTRANS_IDLE;
      HWDATA <= pending_data;
      repeat (4) @(posedge HCLK);
      @(negedge HCLK);
      #1;
      i_checker.report_counts();
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // ================================================
   // timeout
   // ================================================

   always @(posedge HCLK) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         i_checker.report_counts();
         $display("Simulation failed");
         $finish;
      end
   end

endmodule

// ==== verification/lcd_ahb_checker.sv ====
// reference model and scoreboard for the LCD AHB-Lite register file
// mirrors the slave FSM and all thirteen registers and compares every cycle

`timescale 1ns/100ps

module lcd_ahb_checker #(
   parameter lcd_ahb_pkg::ahb_addr_t LCD_BASE = 32'hFFE1_0000
) (
   input  logic                   HCLK,
   input  logic                   HRESET,
   input  logic                   HSEL,
   input  logic                   HWRITE,
   input  lcd_ahb_pkg::ahb_addr_t HADDR,
   input  lcd_ahb_pkg::htrans_t   HTRANS,
   input  lcd_ahb_pkg::ahb_data_t HWDATA,
   input  lcd_ahb_pkg::ahb_data_t HRDATA,
   input  logic                   HREADY,
   input  lcd_ahb_pkg::ahb_data_t lcd_timh,
   input  lcd_ahb_pkg::ahb_data_t lcd_timv,
   input  lcd_ahb_pkg::ahb_data_t lcd_pol,
   input  lcd_ahb_pkg::ahb_data_t lcd_le,
   input  lcd_ahb_pkg::ahb_data_t lcd_upbase,
   input  lcd_ahb_pkg::ahb_data_t lcd_lpbase,
   input  lcd_ahb_pkg::ahb_data_t lcd_ctrl,
   input  lcd_ahb_pkg::ahb_data_t crsr_ctrl,
   input  lcd_ahb_pkg::ahb_data_t crsr_cfg,
   input  lcd_ahb_pkg::ahb_data_t crsr_pal0,
   input  lcd_ahb_pkg::ahb_data_t crsr_pal1,
   input  lcd_ahb_pkg::ahb_data_t crsr_xy,
   input  lcd_ahb_pkg::ahb_data_t crsr_clip,
   output int                     error_count
);

   localparam int NUM_REGS = 13;

   lcd_ahb_pkg::slave_state_t m_state;
   lcd_ahb_pkg::ahb_addr_t    m_addr;
   lcd_ahb_pkg::ahb_data_t    m_regs [NUM_REGS];
   lcd_ahb_pkg::ahb_data_t    dut_regs [NUM_REGS];
   int                        hready_errors = 0;
   int                        hrdata_errors = 0;
   int                        reg_errors    = 0;

   // timing block in slots 0 to 6 and cursor block in 7 to 12
   assign dut_regs[0]  = lcd_timh;
   assign dut_regs[1]  = lcd_timv;
   assign dut_regs[2]  = lcd_pol;
   assign dut_regs[3]  = lcd_le;
   assign dut_regs[4]  = lcd_upbase;
   assign dut_regs[5]  = lcd_lpbase;
   assign dut_regs[6]  = lcd_ctrl;
   assign dut_regs[7]  = crsr_ctrl;
   assign dut_regs[8]  = crsr_cfg;
   assign dut_regs[9]  = crsr_pal0;
   assign dut_regs[10] = crsr_pal1;
   assign dut_regs[11] = crsr_xy;
   assign dut_regs[12] = crsr_clip;

   assign error_count = hready_errors + hrdata_errors + reg_errors;

   // model slot for an address or -1 when nothing is mapped there
   function automatic int reg_slot(input lcd_ahb_pkg::ahb_addr_t addr);
      lcd_ahb_pkg::reg_index_t idx;
      idx = addr[5:2];
      if (addr[31:12] != LCD_BASE[31:12]) begin
         return -1;
      end
      if ((addr[11:10] == lcd_ahb_pkg::LCD_BLOCK_SEL) && (idx <= lcd_ahb_pkg::LCD_CTRL_IDX)) begin
         return int'(idx);
      end
      if ((addr[11:10] == lcd_ahb_pkg::CRSR_BLOCK_SEL) && (idx <= lcd_ahb_pkg::CRSR_CLIP_IDX)) begin
         return 7 + int'(idx);
      end
      return -1;
   endfunction

   // output port name of a model slot
   function automatic string reg_name(input int slot);
      case (slot)
         0:       return "lcd_timh";
         1:       return "lcd_timv";
         2:       return "lcd_pol";
         3:       return "lcd_le";
         4:       return "lcd_upbase";
         5:       return "lcd_lpbase";
         6:       return "lcd_ctrl";
         7:       return "crsr_ctrl";
         8:       return "crsr_cfg";
         9:       return "crsr_pal0";
         10:      return "crsr_pal1";
         11:      return "crsr_xy";
         12:      return "crsr_clip";
         default: return "register";
      endcase
   endfunction

   function automatic lcd_ahb_pkg::slave_state_t next_state(input lcd_ahb_pkg::slave_state_t st);
      if (!HSEL) begin
         return lcd_ahb_pkg::ST_IDLE;
      end
      if (st == lcd_ahb_pkg::ST_IDLE) begin
         return lcd_ahb_pkg::ST_ADDR;
      end
      // first transfer takes NONSEQ or SEQ but a chain continues on NONSEQ only
      if ((st == lcd_ahb_pkg::ST_ADDR && HTRANS[1]) || HTRANS == lcd_ahb_pkg::HTRANS_NONSEQ) begin
         return HWRITE ? lcd_ahb_pkg::ST_WRITE : lcd_ahb_pkg::ST_READ;
      end
      return lcd_ahb_pkg::ST_IDLE;
   endfunction

   task automatic report_counts();
      $display("error counts: HREADY %0d, HRDATA %0d, registers %0d, total %0d",
               hready_errors, hrdata_errors, reg_errors, error_count);
   endtask

   // ================================================
   // compare mid-cycle and then step the model
   // ================================================

   always @(negedge HCLK) begin
      lcd_ahb_pkg::slave_state_t nxt;
      lcd_ahb_pkg::ahb_data_t    exp_rdata;
      logic                      exp_ready;
      int                        slot;
      if (!HRESET) begin
         m_state = lcd_ahb_pkg::ST_IDLE;
         m_addr  = '0;
         for (int i = 0; i < NUM_REGS; i++) begin
            m_regs[i] = '0;
         end
      end
      exp_ready = (m_state != lcd_ahb_pkg::ST_IDLE);
      if (HREADY !== exp_ready) begin
         hready_errors++;
         $display("MISMATCH HREADY got %h expected %h at %0t", HREADY, exp_ready, $time);
      end
      slot      = reg_slot(m_addr);
      exp_rdata = '0;
      if ((m_state == lcd_ahb_pkg::ST_READ) && (slot >= 0)) begin
         exp_rdata = m_regs[slot];
      end
      if (HRDATA !== exp_rdata) begin
         hrdata_errors++;
         $display("MISMATCH HRDATA got %h expected %h at %0t", HRDATA, exp_rdata, $time);
      end
      for (int i = 0; i < NUM_REGS; i++) begin
         if (dut_regs[i] !== m_regs[i]) begin
            reg_errors++;
            $display("MISMATCH %s got %h expected %h at %0t",
                     reg_name(i), dut_regs[i], m_regs[i], $time);
         end
      end
      if (HRESET) begin
         nxt = next_state(m_state);
         // data phase write lands at the coming edge
         if ((m_state == lcd_ahb_pkg::ST_WRITE) && (slot >= 0)) begin
            m_regs[slot] = HWDATA;
         end
         if ((m_state == lcd_ahb_pkg::ST_ADDR) ||
             ((m_state == lcd_ahb_pkg::ST_WRITE || m_state == lcd_ahb_pkg::ST_READ) &&
              HTRANS == lcd_ahb_pkg::HTRANS_NONSEQ)) begin
            m_addr = HADDR;
         end
         m_state = nxt;
      end
   end

endmodule

// ==== verilog/lcd_ahb_regs.sv ====
// top level of the LCD AHB-Lite register file
// slave controller plus timing and cursor register blocks

`timescale 1ns/100ps

module lcd_ahb_regs #(
   parameter lcd_ahb_pkg::ahb_addr_t LCD_BASE = 32'hFFE1_0000
) (
   input  logic                   HCLK,
   input  logic                   HRESET,
   input  logic                   HSEL,
   input  logic                   HWRITE,
   input  lcd_ahb_pkg::ahb_addr_t HADDR,
   input  lcd_ahb_pkg::htrans_t   HTRANS,
   input  lcd_ahb_pkg::ahb_data_t HWDATA,
   output lcd_ahb_pkg::ahb_data_t HRDATA,
   output logic                   HREADY,
   // register outputs to the display logic
   output lcd_ahb_pkg::ahb_data_t lcd_timh,
   output lcd_ahb_pkg::ahb_data_t lcd_timv,
   output lcd_ahb_pkg::ahb_data_t lcd_pol,
   output lcd_ahb_pkg::ahb_data_t lcd_le,
   output lcd_ahb_pkg::ahb_data_t lcd_upbase,
   output lcd_ahb_pkg::ahb_data_t lcd_lpbase,
   output lcd_ahb_pkg::ahb_data_t lcd_ctrl,
   output lcd_ahb_pkg::ahb_data_t crsr_ctrl,
   output lcd_ahb_pkg::ahb_data_t crsr_cfg,
   output lcd_ahb_pkg::ahb_data_t crsr_pal0,
   output lcd_ahb_pkg::ahb_data_t crsr_pal1,
   output lcd_ahb_pkg::ahb_data_t crsr_xy,
   output lcd_ahb_pkg::ahb_data_t crsr_clip
);

   lcd_ahb_pkg::reg_index_t reg_index;
   lcd_ahb_pkg::ahb_data_t  lcd_rdata;
   lcd_ahb_pkg::ahb_data_t  crsr_rdata;
   logic                    lcd_wr_en;
   logic                    crsr_wr_en;

   // bus side, owns the page and block decode
   ahb_slave_ctrl #(
      .LCD_BASE (LCD_BASE)
   ) i_ahb_slave_ctrl (
      .HCLK       (HCLK),
      .HRESET     (HRESET),
      .HSEL       (HSEL),
      .HWRITE     (HWRITE),
      .HADDR      (HADDR),
      .HTRANS     (HTRANS),
      .lcd_rdata  (lcd_rdata),
      .crsr_rdata (crsr_rdata),
      .HRDATA     (HRDATA),
      .HREADY     (HREADY),
      .reg_index  (reg_index),
      .lcd_wr_en  (lcd_wr_en),
      .crsr_wr_en (crsr_wr_en)
   );

   lcd_timing_regs i_lcd_timing_regs (
      .HCLK       (HCLK),
      .HRESET     (HRESET),
      .lcd_wr_en  (lcd_wr_en),
      .reg_index  (reg_index),
      .HWDATA     (HWDATA),
      .lcd_rdata  (lcd_rdata),
      .lcd_timh   (lcd_timh),
      .lcd_timv   (lcd_timv),
      .lcd_pol    (lcd_pol),
      .lcd_le     (lcd_le),
      .lcd_upbase (lcd_upbase),
      .lcd_lpbase (lcd_lpbase),
      .lcd_ctrl   (lcd_ctrl)
   );

   lcd_cursor_regs i_lcd_cursor_regs (
      .HCLK       (HCLK),
      .HRESET     (HRESET),
      .crsr_wr_en (crsr_wr_en),
      .reg_index  (reg_index),
      .HWDATA     (HWDATA),
      .crsr_rdata (crsr_rdata),
      .crsr_ctrl  (crsr_ctrl),
      .crsr_cfg   (crsr_cfg),
      .crsr_pal0  (crsr_pal0),
      .crsr_pal1  (crsr_pal1),
      .crsr_xy    (crsr_xy),
      .crsr_clip  (crsr_clip)
   );

endmodule

// ==== verilog/lcd_cursor_regs.sv ====
// hardware cursor register block
// control, configuration, two palette entries, position and clip

`timescale 1ns/100ps

module lcd_cursor_regs (
   input  logic                    HCLK,
   input  logic                    HRESET,
   input  logic                    crsr_wr_en,
   input  lcd_ahb_pkg::reg_index_t reg_index,
   input  lcd_ahb_pkg::ahb_data_t  HWDATA,
   output lcd_ahb_pkg::ahb_data_t  crsr_rdata,
   output lcd_ahb_pkg::ahb_data_t  crsr_ctrl,
   output lcd_ahb_pkg::ahb_data_t  crsr_cfg,
   output lcd_ahb_pkg::ahb_data_t  crsr_pal0,
   output lcd_ahb_pkg::ahb_data_t  crsr_pal1,
   output lcd_ahb_pkg::ahb_data_t  crsr_xy,
   output lcd_ahb_pkg::ahb_data_t  crsr_clip
);

   // ================================================
   // register write
   // ================================================

   always_ff @(posedge HCLK or negedge HRESET) begin
      if (!HRESET) begin
         crsr_ctrl <= '0;
         crsr_cfg  <= '0;
         crsr_pal0 <= '0;
         crsr_pal1 <= '0;
         crsr_xy   <= '0;
         crsr_clip <= '0;
      end else if (crsr_wr_en) begin
         case (reg_index)
            lcd_ahb_pkg::CRSR_CTRL_IDX: crsr_ctrl <= HWDATA;
            lcd_ahb_pkg::CRSR_CFG_IDX:  crsr_cfg  <= HWDATA;
            lcd_ahb_pkg::CRSR_PAL0_IDX: crsr_pal0 <= HWDATA;
            lcd_ahb_pkg::CRSR_PAL1_IDX: crsr_pal1 <= HWDATA;
            lcd_ahb_pkg::CRSR_XY_IDX:   crsr_xy   <= HWDATA;
            lcd_ahb_pkg::CRSR_CLIP_IDX: crsr_clip <= HWDATA;
            // unmapped, 6 to 15
            default: begin
            end
         endcase
      end
   end

   // ================================================
   // read back
   // ================================================

   always_comb begin
      case (reg_index)
         lcd_ahb_pkg::CRSR_CTRL_IDX: crsr_rdata = crsr_ctrl;
         lcd_ahb_pkg::CRSR_CFG_IDX:  crsr_rdata = crsr_cfg;
         lcd_ahb_pkg::CRSR_PAL0_IDX: crsr_rdata = crsr_pal0;
         lcd_ahb_pkg::CRSR_PAL1_IDX: crsr_rdata = crsr_pal1;
         lcd_ahb_pkg::CRSR_XY_IDX:   crsr_rdata = crsr_xy;
         lcd_ahb_pkg::CRSR_CLIP_IDX: crsr_rdata = crsr_clip;
         default:                    crsr_rdata = '0;
      endcase
   end

   a_index_known: assert property (@(posedge HCLK) disable iff (!HRESET)
      crsr_wr_en |-> !$isunknown(reg_index));

endmodule

// ==== verilog/lcd_timing_regs.sv ====
// LCD timing and frame register block
// horizontal/vertical timing, polarity, line end, frame bases and control

`timescale 1ns/100ps

module lcd_timing_regs (
   input  logic                    HCLK,
   input  logic                    HRESET,
   input  logic                    lcd_wr_en,
   input  lcd_ahb_pkg::reg_index_t reg_index,
   input  lcd_ahb_pkg::ahb_data_t  HWDATA,
   output lcd_ahb_pkg::ahb_data_t  lcd_rdata,
   output lcd_ahb_pkg::ahb_data_t  lcd_timh,
   output lcd_ahb_pkg::ahb_data_t  lcd_timv,
   output lcd_ahb_pkg::ahb_data_t  lcd_pol,
   output lcd_ahb_pkg::ahb_data_t  lcd_le,
   output lcd_ahb_pkg::ahb_data_t  lcd_upbase,
   output lcd_ahb_pkg::ahb_data_t  lcd_lpbase,
   output lcd_ahb_pkg::ahb_data_t  lcd_ctrl
);

   // ================================================
   // register write
   // ================================================

   always_ff @(posedge HCLK or negedge HRESET) begin
      if (!HRESET) begin
         lcd_timh   <= '0;
         lcd_timv   <= '0;
         lcd_pol    <= '0;
         lcd_le     <= '0;
         lcd_upbase <= '0;
         lcd_lpbase <= '0;
         lcd_ctrl   <= '0;
      end else if (lcd_wr_en) begin
         case (reg_index)
            lcd_ahb_pkg::LCD_TIMH_IDX:   lcd_timh   <= HWDATA;
            lcd_ahb_pkg::LCD_TIMV_IDX:   lcd_timv   <= HWDATA;
            lcd_ahb_pkg::LCD_POL_IDX:    lcd_pol    <= HWDATA;
            lcd_ahb_pkg::LCD_LE_IDX:     lcd_le     <= HWDATA;
            lcd_ahb_pkg::LCD_UPBASE_IDX: lcd_upbase <= HWDATA;
            lcd_ahb_pkg::LCD_LPBASE_IDX: lcd_lpbase <= HWDATA;
            lcd_ahb_pkg::LCD_CTRL_IDX:   lcd_ctrl   <= HWDATA;
            // indices 7 to 15 are not mapped, write is dropped
            default: begin
            end
         endcase
      end
   end

   // ================================================
   // read back
   // ================================================

   always_comb begin
      case (reg_index)
         lcd_ahb_pkg::LCD_TIMH_IDX:   lcd_rdata = lcd_timh;
         lcd_ahb_pkg::LCD_TIMV_IDX:   lcd_rdata = lcd_timv;
         lcd_ahb_pkg::LCD_POL_IDX:    lcd_rdata = lcd_pol;
         lcd_ahb_pkg::LCD_LE_IDX:     lcd_rdata = lcd_le;
         lcd_ahb_pkg::LCD_UPBASE_IDX: lcd_rdata = lcd_upbase;
         lcd_ahb_pkg::LCD_LPBASE_IDX: lcd_rdata = lcd_lpbase;
         lcd_ahb_pkg::LCD_CTRL_IDX:   lcd_rdata = lcd_ctrl;
         default:                     lcd_rdata = '0;
      endcase
   end

   // index must be resolved whenever the controller strobes a write
   a_index_known: assert property (@(posedge HCLK) disable iff (!HRESET)
      lcd_wr_en |-> !$isunknown(reg_index));

endmodule

// ==== verilog/ahb_slave_ctrl.sv ====
// AHB-Lite slave controller for the LCD register page
// four-state slave FSM, address capture, block decode, read-data select

`timescale 1ns/100ps

module ahb_slave_ctrl #(
   parameter lcd_ahb_pkg::ahb_addr_t LCD_BASE = 32'hFFE1_0000
) (
   input  logic                    HCLK,
   input  logic                    HRESET,
   input  logic                    HSEL,
   input  logic                    HWRITE,
   input  lcd_ahb_pkg::ahb_addr_t  HADDR,
   input  lcd_ahb_pkg::htrans_t    HTRANS,
   input  lcd_ahb_pkg::ahb_data_t  lcd_rdata,
   input  lcd_ahb_pkg::ahb_data_t  crsr_rdata,
   output lcd_ahb_pkg::ahb_data_t  HRDATA,
   output logic                    HREADY,
   output lcd_ahb_pkg::reg_index_t reg_index,
   output logic                    lcd_wr_en,
   output logic                    crsr_wr_en
);

   lcd_ahb_pkg::slave_state_t state_q;
   lcd_ahb_pkg::slave_state_t state_nxt;
   lcd_ahb_pkg::ahb_addr_t    addr_q;
   logic                      addr_load;
   logic                      in_data_phase;
   logic                      page_hit;
   logic [1:0]                blk_sel;

   // ================================================
   // slave FSM
   // ================================================

   always_ff @(posedge HCLK or negedge HRESET) begin
      if (!HRESET) begin
         state_q <= lcd_ahb_pkg::ST_IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = lcd_ahb_pkg::ST_IDLE;
      case (state_q)
         lcd_ahb_pkg::ST_IDLE: begin
            if (HSEL) begin
               state_nxt = lcd_ahb_pkg::ST_ADDR;
            end
         end
         // first transfer accepts NONSEQ or SEQ
         lcd_ahb_pkg::ST_ADDR: begin
            if (HSEL && HTRANS[1]) begin
               state_nxt = HWRITE ? lcd_ahb_pkg::ST_WRITE : lcd_ahb_pkg::ST_READ;
            end
         end
         // only NONSEQ keeps the chain going and SEQ or BUSY drops back to idle
         lcd_ahb_pkg::ST_WRITE, lcd_ahb_pkg::ST_READ: begin
            if (HSEL && (HTRANS == lcd_ahb_pkg::HTRANS_NONSEQ)) begin
               state_nxt = HWRITE ? lcd_ahb_pkg::ST_WRITE : lcd_ahb_pkg::ST_READ;
            end
         end
         default: begin
            state_nxt = lcd_ahb_pkg::ST_IDLE;
         end
      endcase
   end

   // not ready while idle and one cycle in every other state
   assign HREADY = (state_q != lcd_ahb_pkg::ST_IDLE);

   // ================================================
   // address capture and decode
   // ================================================

   assign in_data_phase = (state_q == lcd_ahb_pkg::ST_WRITE) ||
                          (state_q == lcd_ahb_pkg::ST_READ);

   // next address overlaps the current data phase
   assign addr_load = (state_q == lcd_ahb_pkg::ST_ADDR) ||
                      (in_data_phase && (HTRANS == lcd_ahb_pkg::HTRANS_NONSEQ));

   always_ff @(posedge HCLK or negedge HRESET) begin
      if (!HRESET) begin
         addr_q <= '0;
      end else if (addr_load) begin
         addr_q <= HADDR;
      end
   end

   // 4 KB page compare ignores the low 12 bits of the base
   assign page_hit  = (addr_q[31:12] == LCD_BASE[31:12]);
   assign blk_sel   = addr_q[11:10];
   assign reg_index = addr_q[5:2];

   assign lcd_wr_en  = (state_q == lcd_ahb_pkg::ST_WRITE) && page_hit &&
                       (blk_sel == lcd_ahb_pkg::LCD_BLOCK_SEL);
   assign crsr_wr_en = (state_q == lcd_ahb_pkg::ST_WRITE) && page_hit &&
                       (blk_sel == lcd_ahb_pkg::CRSR_BLOCK_SEL);

   // read data only in the read data phase and zero in all others
   always_comb begin
      HRDATA = '0;
      if ((state_q == lcd_ahb_pkg::ST_READ) && page_hit) begin
         if (blk_sel == lcd_ahb_pkg::LCD_BLOCK_SEL) begin
            HRDATA = lcd_rdata;
         end else if (blk_sel == lcd_ahb_pkg::CRSR_BLOCK_SEL) begin
            HRDATA = crsr_rdata;
         end
      end
   end

   // ================================================
   // checks
   // ================================================

   // a strobe follows a write transfer and picks exactly one block
   a_one_strobe: assert property (@(posedge HCLK) disable iff (!HRESET)
      (lcd_wr_en || crsr_wr_en) |-> ($past(HWRITE) && (lcd_wr_en != crsr_wr_en)));

   // deselect returns the slave to idle and drops HREADY
   a_idle_not_ready: assert property (@(posedge HCLK) disable iff (!HRESET)
      !$past(HSEL) |-> !HREADY);

endmodule

// ==== verilog/lcd_ahb_pkg.sv ====
// shared types and constants for the LCD AHB-Lite register file
// bus widths, transfer codes, slave FSM states and register word indices

package lcd_ahb_pkg;

   // ================================================
   // bus types
   // ================================================

   // byte address on the AHB bus
   typedef logic [31:0] ahb_addr_t;

   // data word, also the width of every register
   typedef logic [31:0] ahb_data_t;

   // HTRANS encoding
   typedef logic [1:0] htrans_t;

   localparam htrans_t HTRANS_IDLE   = 2'b00;
   localparam htrans_t HTRANS_BUSY   = 2'b01;
   localparam htrans_t HTRANS_NONSEQ = 2'b10;
   localparam htrans_t HTRANS_SEQ    = 2'b11;

   // ================================================
   // slave FSM
   // ================================================

   // idle -> address phase -> write or read data phase
   typedef enum logic [1:0] {
      ST_IDLE  = 2'b00,
      ST_ADDR  = 2'b01,
      ST_WRITE = 2'b10,
      ST_READ  = 2'b11
   } slave_state_t;

   // ================================================
   // register map
   // ================================================

   // word index inside a block, address bits 5:2
   typedef logic [3:0] reg_index_t;

   // timing block
   localparam reg_index_t LCD_TIMH_IDX   = 4'd0;
   localparam reg_index_t LCD_TIMV_IDX   = 4'd1;
   localparam reg_index_t LCD_POL_IDX    = 4'd2;
   localparam reg_index_t LCD_LE_IDX     = 4'd3;
   localparam reg_index_t LCD_UPBASE_IDX = 4'd4;
   localparam reg_index_t LCD_LPBASE_IDX = 4'd5;
   localparam reg_index_t LCD_CTRL_IDX   = 4'd6;

   // cursor block
   localparam reg_index_t CRSR_CTRL_IDX = 4'd0;
   localparam reg_index_t CRSR_CFG_IDX  = 4'd1;
   localparam reg_index_t CRSR_PAL0_IDX = 4'd2;
   localparam reg_index_t CRSR_PAL1_IDX = 4'd3;
   localparam reg_index_t CRSR_XY_IDX   = 4'd4;
   localparam reg_index_t CRSR_CLIP_IDX = 4'd5;

   // block select in address bits 11:10
   localparam logic [1:0] LCD_BLOCK_SEL  = 2'd0;
   localparam logic [1:0] CRSR_BLOCK_SEL = 2'd3;

endpackage
